// File: verification/kavach_golden.txt
# name vdd idd temp | level type score response(hex: irq,throttle,isolate,lock,zero) capture
# Thresholds: volt 200, curr 150, temp hi 150, temp lo 100, sustain 3, clear 2
prime        1000 500 120  0 0   0 00 0
ewma         1032 500 120  0 0   0 00 0
volt_glitch  1600 500 120  2 1  64 18 1
after_glitch 1000 500 120  2 1  64 18 0
glitch_clear 1000 500 120  0 0   0 00 0
temp_hi      1000 500 160  2 2  64 18 1
temp_hi2     1000 500 160  2 2  64 18 0
sustained    1000 500 160  3 2  96 1c 1
cool         1000 500 120  3 2  96 1c 0
cool_clear   1000 500 120  0 0   0 00 0
temp_lo      1000 500  90  1 2  32 10 0
lo_hold      1000 500 120  1 2  32 10 0
lo_clear     1000 500 120  0 0   0 00 0
combined     1300 500 160  3 3  96 1c 1
lower_holds  1300 500 120  3 3  96 1c 0
critical     1900 500 160  4 3 160 1f 1
crit_hold    1000 500 120  4 3 160 1f 0
crit_clear   1000 500 120  0 0   0 03 0
locked_quiet 1000 500 120  0 0   0 03 0
curr_glitch  1000 700 120  1 1  32 13 0
curr_hold    1000 500 120  1 1  32 13 0
curr_clear   1000 500 120  0 0   0 03 0

// File: list.f
source/kavach_pkg.sv
source/kavach_power_monitor.sv
source/kavach_temp_monitor.sv
source/kavach_threat_classifier.sv
source/kavach_response_controller.sv
source/kavach_forensic_log.sv
source/kavach_top.sv
verification/kavach_checker.sv
verification/kavach_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the kavach testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module kavach_tb -o kavach_sim \
    && ./obj_dir/kavach_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }

// File: verification/kavach_tb.sv
// ============================================================================
// Testbench for kavach_top, driven from verification/kavach_golden.txt
// Run from the project root; one frame every 4 cycles, then log readout
// ============================================================================

`timescale 1ns/1ps

module kavach_tb;

    import kavach_pkg::*;

    localparam int ACK_HOLD     = 5;
    localparam int FRAME_CYCLES = 4;

    logic            clk;
    logic            reset;
    adc_sample_t     vdd_sample;
    adc_sample_t     idd_sample;
    adc_sample_t     temp_sample;
    logic            sample_valid;
    logic [2:0]      read_slot;
    logic            read_req;
    logic            read_ack;
    threat_t         threat;
    response_t       response;
    forensic_entry_t entry;
    logic            read_valid;
    logic [3:0]      log_count;
    int unsigned     cycle = 0;
    logic            loaded = 1'b0;

    string name_q[$];
    int    vdd_q[$];
    int    idd_q[$];
    int    temp_q[$];
    int    lvl_q[$];
    int    typ_q[$];
    int    score_q[$];
    int    resp_q[$];
    // Expected log contents, in capture order
    threat_t cap_threat_q[$];
    int      cap_vdd_q[$];
    int      cap_temp_q[$];
    int      cap_frame_q[$];
    // Timestamps read back from the log
    logic [TIMESTAMP_WIDTH-1:0] stamp_q[$];

    kavach_top kavach_top_inst (
        .clk                 (clk),
        .reset               (reset),
        .vdd_sample          (vdd_sample),
        .idd_sample          (idd_sample),
        .temp_sample         (temp_sample),
        .sample_valid        (sample_valid),
        .forensic_read_slot  (read_slot),
        .forensic_read_req   (read_req),
        .forensic_read_ack   (read_ack),
        .threat              (threat),
        .response            (response),
        .forensic_entry      (entry),
        .forensic_read_valid (read_valid),
        .forensic_count      (log_count)
    );

    kavach_checker checker_inst (
        .clk      (clk),
        .cycle    (cycle),
        .threat   (threat),
        .response (response)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic threat_t make_threat(input int lvl, input int typ, input int score);
        threat_t t;
        t.level       = threat_level_e'(lvl[2:0]);
        t.attack_type = attack_type_e'(typ[3:0]);
        t.score       = score[7:0];
        return t;
    endfunction

    // ========================================================================
    // Golden file parsing
    // ========================================================================
    task automatic load_golden(output bit ok);
        int    fd;
        int    n;
        string line;
        string name;
        int    v;
        int    i;
        int    t;
        int    lvl;
        int    typ;
        int    sc;
        int    rsp;
        int    cap;
        ok = 1'b0;
        fd = $fopen("verification/kavach_golden.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == 8'h23)
                    continue;
                n = $sscanf(line, "%s %d %d %d %d %d %d %h %d",
                            name, v, i, t, lvl, typ, sc, rsp, cap);
                if (n != 9)
                    continue;
                name_q.push_back(name);
                vdd_q.push_back(v);
                idd_q.push_back(i);
                temp_q.push_back(t);
                lvl_q.push_back(lvl);
                typ_q.push_back(typ);
                score_q.push_back(sc);
                resp_q.push_back(rsp);
                if (cap != 0) begin
                    cap_threat_q.push_back(make_threat(lvl, typ, sc));
                    cap_vdd_q.push_back(v);
                    cap_temp_q.push_back(t);
                    cap_frame_q.push_back(name_q.size() - 1);
                end
            end
            $fclose(fd);
        end
    endtask

    // Frame cycle is the cycle in which sample_valid is high
    task automatic send_frame(input int idx);
        int rsp;
        rsp = resp_q[idx];
        @(posedge clk);
        vdd_sample   <= 12'(vdd_q[idx]);
        idd_sample   <= 12'(idd_q[idx]);
        temp_sample  <= 12'(temp_q[idx]);
        sample_valid <= 1'b1;
        checker_inst.add_expect(name_q[idx], cycle + 1,
                                make_threat(lvl_q[idx], typ_q[idx], score_q[idx]),
                                response_t'(rsp[4:0]));
        @(posedge clk);
        sample_valid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // ========================================================================
    // Log readout with optional ack delay
    // ========================================================================
    task automatic read_log_slot(input int slot, input int hold);
        forensic_entry_t held;
        int              waited;
        string           tag;
        tag = $sformatf("slot%0d", slot);
        @(posedge clk);
        read_slot <= 3'(slot);
        read_req  <= 1'b1;
        @(posedge clk);
        read_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!read_valid && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!read_valid) begin
            checker_inst.report_failure({tag, ": read_valid never rose"});
            return;
        end
        checker_inst.check_value({tag, " threat"}, 32'(cap_threat_q[slot]),
                                 32'(entry.threat));
        checker_inst.check_value({tag, " snap_vdd"}, 32'(cap_vdd_q[slot]),
                                 32'(entry.snap_vdd));
        checker_inst.check_value({tag, " snap_temp"}, 32'(cap_temp_q[slot]),
                                 32'(entry.snap_temp));
        stamp_q.push_back(entry.timestamp);
        held = entry;
        // A new request while valid is high must be ignored
        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            read_req  <= (k == 0);
            read_slot <= 3'(slot + 1);
            @(negedge clk);
            if (!read_valid)
                checker_inst.report_failure({tag, ": read_valid dropped before ack"});
            if (entry !== held)
                checker_inst.report_failure({tag, ": entry changed while waiting for ack"});
        end
        @(posedge clk);
        read_req <= 1'b0;
        read_ack <= 1'b1;
        @(posedge clk);
        read_ack <= 1'b0;
        @(negedge clk);
        if (read_valid)
            checker_inst.report_failure({tag, ": read_valid still high after ack"});
    endtask

    initial begin
        wait (loaded);
        repeat (name_q.size() * 4 + 100) @(posedge clk);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        bit golden_ok;
        reset        = 1'b1;
        vdd_sample   = '0;
        idd_sample   = '0;
        temp_sample  = '0;
        sample_valid = 1'b0;
        read_slot    = '0;
        read_req     = 1'b0;
        read_ack     = 1'b0;
        load_golden(golden_ok);
        if (!golden_ok) begin
            $display("Cannot open the golden file verification/kavach_golden.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            for (int f = 0; f < name_q.size(); f++)
                send_frame(f);
            // Pipeline drains four cycles after the last frame
            repeat (8) @(posedge clk);
            @(negedge clk);
            if (checker_inst.pending_count() != 0)
                checker_inst.report_failure("frame checks: some expectations were never compared");
            checker_inst.check_value("forensic_count", 32'(cap_threat_q.size()),
                                     32'(log_count));
            for (int s = 0; s < cap_threat_q.size(); s++)
                read_log_slot(s, (s == 0) ? ACK_HOLD : 0);
            // Captures sit a fixed latency after their frames, so stamps step with them
            if (stamp_q.size() == cap_frame_q.size()) begin
                for (int s = 1; s < stamp_q.size(); s++)
                    checker_inst.check_value($sformatf("slot%0d timestamp step", s),
                                             32'(FRAME_CYCLES *
                                                 (cap_frame_q[s] - cap_frame_q[s - 1])),
                                             32'(stamp_q[s] - stamp_q[s - 1]));
            end
            $display("Checks: %0d, errors: %0d", checker_inst.check_count,
                     checker_inst.error_count);
            if (checker_inst.error_count == 0)
                $display("Testbench passed");
            else
                $display("Testbench failed");
            $finish;
        end
    end

endmodule

// File: verification/kavach_checker.sv
// ============================================================================
// Compares DUT threat and response with the expected values of each frame
// Threat is checked 2 cycles and response 3 cycles after the frame cycle
// ============================================================================

`timescale 1ns/1ps

module kavach_checker (
    input logic                  clk,
    input int unsigned           cycle,
    input kavach_pkg::threat_t   threat,
    input kavach_pkg::response_t response
);

    import kavach_pkg::*;

    int unsigned thr_cycle_q[$];
    threat_t     thr_exp_q[$];
    string       thr_name_q[$];
    int unsigned rsp_cycle_q[$];
    response_t   rsp_exp_q[$];
    string       rsp_name_q[$];
    int          error_count = 0;
    int          check_count = 0;

    task automatic add_expect(input string name, input int unsigned frame_cycle,
                              input threat_t exp_threat, input response_t exp_response);
        thr_cycle_q.push_back(frame_cycle + 2);
        thr_exp_q.push_back(exp_threat);
        thr_name_q.push_back(name);
        rsp_cycle_q.push_back(frame_cycle + 3);
        rsp_exp_q.push_back(exp_response);
        rsp_name_q.push_back(name);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        check_count++;
        if (exp_val !== act_val) begin
            error_count++;
            $display("ERR %s expected %0h actual %0h", name, exp_val, act_val);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure in %s", msg);
    endtask

    function automatic int pending_count();
        return thr_cycle_q.size() + rsp_cycle_q.size();
    endfunction

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (thr_cycle_q.size() != 0 && cycle == thr_cycle_q[0]) begin
            check_value({thr_name_q[0], " threat"}, 32'(thr_exp_q[0]), 32'(threat));
            thr_cycle_q.delete(0);
            thr_exp_q.delete(0);
            thr_name_q.delete(0);
        end
        if (rsp_cycle_q.size() != 0 && cycle == rsp_cycle_q[0]) begin
            check_value({rsp_name_q[0], " response"}, 32'(rsp_exp_q[0]), 32'(response));
            rsp_cycle_q.delete(0);
            rsp_exp_q.delete(0);
            rsp_name_q.delete(0);
        end
    end

endmodule

// File: source/kavach_top.sv
// =========================================================================
// Kavach chip security monitor top level
// One sensor frame per sample_valid; threat at +2 and response at +3 cycles
// =========================================================================

`timescale 1ns/1ps

module kavach_top #(
    parameter int unsigned             EWMA_SHIFT      = 4,
    parameter kavach_pkg::adc_sample_t VOLT_THRESH     = 12'd200,
    parameter kavach_pkg::adc_sample_t CURR_THRESH     = 12'd150,
    parameter kavach_pkg::adc_sample_t TEMP_HI_THRESH  = 12'd150,
    parameter kavach_pkg::adc_sample_t TEMP_LO_THRESH  = 12'd100,
    parameter int unsigned             SUSTAIN_SAMPLES = 3,
    parameter int unsigned             CLEAR_SAMPLES   = 2,
    parameter int unsigned             LOG_DEPTH       = 8,
    localparam int                     SLOT_W          = $clog2(LOG_DEPTH),
    localparam int                     COUNT_W         = $clog2(LOG_DEPTH + 1)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  kavach_pkg::adc_sample_t     vdd_sample,
    input  kavach_pkg::adc_sample_t     idd_sample,
    input  kavach_pkg::adc_sample_t     temp_sample,
    input  logic                        sample_valid,
    input  logic [SLOT_W-1:0]           forensic_read_slot,
    input  logic                        forensic_read_req,
    input  logic                        forensic_read_ack,
    output kavach_pkg::threat_t         threat,
    output kavach_pkg::response_t       response,
    output kavach_pkg::forensic_entry_t forensic_entry,
    output logic                        forensic_read_valid,
    output logic [COUNT_W-1:0]          forensic_count
);

    import kavach_pkg::*;

    power_flags_t power_flags;
    temp_flags_t  temp_flags;
    logic         flags_valid;
    logic         threat_valid;
    logic         capture_trigger;

    // =====================================================================
    // Sensor monitors
    // =====================================================================
    kavach_power_monitor #(
        .EWMA_SHIFT  (EWMA_SHIFT),
        .VOLT_THRESH (VOLT_THRESH),
        .CURR_THRESH (CURR_THRESH)
    ) u_power_monitor (
        .clk          (clk),
        .reset        (reset),
        .vdd_sample   (vdd_sample),
        .idd_sample   (idd_sample),
        .sample_valid (sample_valid),
        .power_flags  (power_flags),
        .flags_valid  (flags_valid)
    );

    kavach_temp_monitor #(
        .TEMP_HI_THRESH  (TEMP_HI_THRESH),
        .TEMP_LO_THRESH  (TEMP_LO_THRESH),
        .SUSTAIN_SAMPLES (SUSTAIN_SAMPLES)
    ) u_temp_monitor (
        .clk          (clk),
        .reset        (reset),
        .temp_sample  (temp_sample),
        .sample_valid (sample_valid),
        .temp_flags   (temp_flags)
    );

    // =====================================================================
    // Classification and response
    // =====================================================================
    kavach_threat_classifier #(
        .CLEAR_SAMPLES (CLEAR_SAMPLES)
    ) u_threat_classifier (
        .clk          (clk),
        .reset        (reset),
        .power_flags  (power_flags),
        .temp_flags   (temp_flags),
        .flags_valid  (flags_valid),
        .threat       (threat),
        .threat_valid (threat_valid)
    );

    kavach_response_controller u_response_controller (
        .clk             (clk),
        .reset           (reset),
        .threat          (threat),
        .threat_valid    (threat_valid),
        .response        (response),
        .capture_trigger (capture_trigger)
    );

    // =====================================================================
    // Forensic log
    // =====================================================================
    kavach_forensic_log #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_forensic_log (
        .clk             (clk),
        .reset           (reset),
        .capture_trigger (capture_trigger),
        .threat          (threat),
        .vdd_sample      (vdd_sample),
        .temp_sample     (temp_sample),
        .sample_valid    (sample_valid),
        .read_slot       (forensic_read_slot),
        .read_req        (forensic_read_req),
        .read_ack        (forensic_read_ack),
        .entry           (forensic_entry),
        .read_valid      (forensic_read_valid),
        .count           (forensic_count)
    );

endmodule

// File: source/kavach_forensic_log.sv
// =========================================================================
// Circular forensic log of LOG_DEPTH entries; oldest entry is overwritten
// Reads use req, then valid held until the cycle after ack
// A request while valid is high is dropped
// =========================================================================

`timescale 1ns/1ps

module kavach_forensic_log #(
    parameter int unsigned LOG_DEPTH = 8,
    localparam int         SLOT_W    = $clog2(LOG_DEPTH),
    localparam int         COUNT_W   = $clog2(LOG_DEPTH + 1)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        capture_trigger,
    input  kavach_pkg::threat_t         threat,
    input  kavach_pkg::adc_sample_t     vdd_sample,
    input  kavach_pkg::adc_sample_t     temp_sample,
    input  logic                        sample_valid,
    input  logic [SLOT_W-1:0]           read_slot,
    input  logic                        read_req,
    input  logic                        read_ack,
    output kavach_pkg::forensic_entry_t entry,
    output logic                        read_valid,
    output logic [COUNT_W-1:0]          count
);

    import kavach_pkg::*;

    forensic_entry_t            log_mem [LOG_DEPTH];
    logic [SLOT_W-1:0]          wr_ptr;
    logic [TIMESTAMP_WIDTH-1:0] cycle_count;
    adc_sample_t                snap_vdd;
    adc_sample_t                snap_temp;
    forensic_entry_t            new_entry;

    assign new_entry = '{
        timestamp: cycle_count,
        threat:    threat,
        snap_vdd:  snap_vdd,
        snap_temp: snap_temp
    };

    // Samples of the most recent frame
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            snap_vdd  <= vdd_sample;
            snap_temp <= temp_sample;
        end
    end

    // =====================================================================
    // Storage and readout data
    // =====================================================================
    always_ff @(posedge clk) begin
        if (capture_trigger)
            log_mem[wr_ptr] <= new_entry;
        if (read_req && !read_valid)
            entry <= log_mem[read_slot];
    end

    // =====================================================================
    // Timestamp, write pointer, fill count and read handshake
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            read_valid  <= 1'b0;
        end else begin
            cycle_count <= cycle_count + TIMESTAMP_WIDTH'(1);
            if (capture_trigger) begin
                wr_ptr <= (wr_ptr == SLOT_W'(LOG_DEPTH - 1)) ? '0 : wr_ptr + SLOT_W'(1);
                if (count != COUNT_W'(LOG_DEPTH))
                    count <= count + COUNT_W'(1);
            end
            if (read_valid) begin
                if (read_ack)
                    read_valid <= 1'b0;
            end else if (read_req) begin
                read_valid <= 1'b1;
            end
        end
    end

endmodule

// File: source/kavach_response_controller.sv
// =========================================================================
// Protective responses for the current threat level
// Lockdown and zeroize stay set until reset
// A capture fires on each rise in level to MEDIUM or above
// =========================================================================

`timescale 1ns/1ps

module kavach_response_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  kavach_pkg::threat_t   threat,
    input  logic                  threat_valid,
    output kavach_pkg::response_t response,
    output logic                  capture_trigger
);

    import kavach_pkg::*;

    threat_level_e prev_level;
    response_t     response_next;
    logic          is_critical;

    assign is_critical = (threat.level == LVL_CRITICAL);

    // Cumulative by level
    always_comb begin
        response_next.alert_irq       = threat.level >= LVL_LOW;
        response_next.clk_throttle_en = threat.level >= LVL_MEDIUM;
        response_next.bus_isolate     = threat.level >= LVL_HIGH;
        response_next.sys_lockdown    = response.sys_lockdown || is_critical;
        response_next.crypto_zeroize  = response.crypto_zeroize || is_critical;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            response        <= '0;
            capture_trigger <= 1'b0;
            prev_level      <= LVL_NONE;
        end else begin
            capture_trigger <= threat_valid && (threat.level > prev_level) &&
                               (threat.level >= LVL_MEDIUM);
            if (threat_valid) begin
                response   <= response_next;
                prev_level <= threat.level;
            end
        end
    end

endmodule

// File: source/kavach_threat_classifier.sv
// =========================================================================
// Fuses power and thermal severity into one held threat
// Higher or equal candidates take over at once; lower ones are ignored
// until CLEAR_SAMPLES quiet frames in a row drop the threat to none
// =========================================================================

`timescale 1ns/1ps

module kavach_threat_classifier #(
    parameter int unsigned CLEAR_SAMPLES = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  kavach_pkg::power_flags_t power_flags,
    input  kavach_pkg::temp_flags_t  temp_flags,
    input  logic                     flags_valid,
    output kavach_pkg::threat_t      threat,
    output logic                     threat_valid
);

    import kavach_pkg::*;

    localparam int CNT_W = $clog2(CLEAR_SAMPLES + 1);

    severity_e        power_sev;
    severity_e        temp_sev;
    severity_e        peak_sev;
    logic             both_active;
    threat_t          candidate;
    logic [CNT_W-1:0] clear_count;

    assign power_sev   = power_flags.severity;
    assign temp_sev    = temp_flags.severity;
    assign both_active = (power_sev != SEV_NONE) && (temp_sev != SEV_NONE);
    assign peak_sev    = (power_sev > temp_sev) ? power_sev : temp_sev;

    always_comb begin
        // Both domains active escalates one step; SEVERE plus one is CRITICAL
        candidate.level = threat_level_e'({1'b0, peak_sev} + {2'b00, both_active});
        if (both_active)
            candidate.attack_type = ATK_COMBINED;
        else if (power_sev != SEV_NONE)
            candidate.attack_type = ATK_POWER_GLITCH;
        else if (temp_sev != SEV_NONE)
            candidate.attack_type = ATK_THERMAL;
        else
            candidate.attack_type = ATK_NONE;
        candidate.score = (8'(power_sev) + 8'(temp_sev)) << 5;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            threat       <= '0;
            threat_valid <= 1'b0;
            clear_count  <= '0;
        end else begin
            threat_valid <= flags_valid;
            if (flags_valid) begin
                // Run of quiet candidates
                if (candidate.level != LVL_NONE)
                    clear_count <= '0;
                else if (clear_count < CNT_W'(CLEAR_SAMPLES))
                    clear_count <= clear_count + CNT_W'(1);

                if (candidate.level >= threat.level)
                    threat <= candidate;
                else if (candidate.level == LVL_NONE &&
                         clear_count >= CNT_W'(CLEAR_SAMPLES - 1))
                    threat <= '0;
            end
        end
    end

endmodule

// File: source/kavach_temp_monitor.sv
// =========================================================================
// Absolute temperature limits with a sustained overheat count
// Flags are registered with the same latency as the power monitor
// =========================================================================

`timescale 1ns/1ps

module kavach_temp_monitor #(
    parameter kavach_pkg::adc_sample_t TEMP_HI_THRESH  = 12'd150,
    parameter kavach_pkg::adc_sample_t TEMP_LO_THRESH  = 12'd100,
    parameter int unsigned             SUSTAIN_SAMPLES = 3
) (
    input  logic                    clk,
    input  logic                    reset,
    input  kavach_pkg::adc_sample_t temp_sample,
    input  logic                    sample_valid,
    output kavach_pkg::temp_flags_t temp_flags
);

    import kavach_pkg::*;

    localparam int CNT_W = $clog2(SUSTAIN_SAMPLES + 1);

    logic [CNT_W-1:0] hi_count;
    logic [CNT_W-1:0] hi_count_next;
    temp_flags_t      flags_next;

    // Consecutive hi frames, saturating at the sustain limit
    always_comb begin
        if (!(temp_sample > TEMP_HI_THRESH))
            hi_count_next = '0;
        else if (hi_count == CNT_W'(SUSTAIN_SAMPLES))
            hi_count_next = hi_count;
        else
            hi_count_next = hi_count + CNT_W'(1);
    end

    always_comb begin
        flags_next.temp_hi   = temp_sample > TEMP_HI_THRESH;
        flags_next.temp_lo   = temp_sample < TEMP_LO_THRESH;
        flags_next.sustained = hi_count_next >= CNT_W'(SUSTAIN_SAMPLES);
        if (flags_next.sustained)
            flags_next.severity = SEV_SEVERE;
        else if (flags_next.temp_hi)
            flags_next.severity = SEV_MAJOR;
        else if (flags_next.temp_lo)
            flags_next.severity = SEV_MINOR;
        else
            flags_next.severity = SEV_NONE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_count   <= '0;
            temp_flags <= '0;
        end else if (sample_valid) begin
            hi_count   <= hi_count_next;
            temp_flags <= flags_next;
        end
    end

endmodule

// File: source/kavach_power_monitor.sv
// =========================================================================
// Voltage and current anomaly detector with EWMA baselines
// First frame after reset seeds the baselines and never flags
// A baseline only tracks frames that are not anomalous on its channel
// =========================================================================

`timescale 1ns/1ps

module kavach_power_monitor #(
    parameter int unsigned             EWMA_SHIFT  = 4,
    parameter kavach_pkg::adc_sample_t VOLT_THRESH = 12'd200,
    parameter kavach_pkg::adc_sample_t CURR_THRESH = 12'd150
) (
    input  logic                     clk,
    input  logic                     reset,
    input  kavach_pkg::adc_sample_t  vdd_sample,
    input  kavach_pkg::adc_sample_t  idd_sample,
    input  logic                     sample_valid,
    output kavach_pkg::power_flags_t power_flags,
    output logic                     flags_valid
);

    import kavach_pkg::*;

    // Grade a delta in steps of 1x, 2x and 4x the threshold
    function automatic severity_e grade(input adc_sample_t delta, input adc_sample_t thresh);
        logic [13:0] d;
        logic [13:0] t;
        d = {2'b00, delta};
        t = {2'b00, thresh};
        if (d <= t)
            return SEV_NONE;
        else if (d <= (t << 1))
            return SEV_MINOR;
        else if (d <= (t << 2))
            return SEV_MAJOR;
        return SEV_SEVERE;
    endfunction

    adc_sample_t        volt_base;
    adc_sample_t        curr_base;
    logic               primed;
    logic signed [12:0] volt_diff;
    logic signed [12:0] curr_diff;
    adc_sample_t        volt_delta;
    adc_sample_t        curr_delta;
    severity_e          volt_sev;
    severity_e          curr_sev;
    power_flags_t       flags_next;

    assign volt_diff  = $signed({1'b0, vdd_sample}) - $signed({1'b0, volt_base});
    assign curr_diff  = $signed({1'b0, idd_sample}) - $signed({1'b0, curr_base});
    assign volt_delta = volt_diff[12] ? adc_sample_t'(-volt_diff) : adc_sample_t'(volt_diff);
    assign curr_delta = curr_diff[12] ? adc_sample_t'(-curr_diff) : adc_sample_t'(curr_diff);
    assign volt_sev   = grade(volt_delta, VOLT_THRESH);
    assign curr_sev   = grade(curr_delta, CURR_THRESH);

    assign flags_next.volt_anomaly = (volt_sev != SEV_NONE);
    assign flags_next.curr_anomaly = (curr_sev != SEV_NONE);
    assign flags_next.severity     = (volt_sev > curr_sev) ? volt_sev : curr_sev;

    always_ff @(posedge clk) begin
        if (reset) begin
            primed      <= 1'b0;
            volt_base   <= '0;
            curr_base   <= '0;
            power_flags <= '0;
            flags_valid <= 1'b0;
        end else begin
            flags_valid <= sample_valid;
            if (sample_valid) begin
                if (!primed) begin
                    primed      <= 1'b1;
                    volt_base   <= vdd_sample;
                    curr_base   <= idd_sample;
                    power_flags <= '0;
                end else begin
                    power_flags <= flags_next;
                    // Baseline moves toward the sample by diff / 2^EWMA_SHIFT
                    if (!flags_next.volt_anomaly)
                        volt_base <= volt_base + adc_sample_t'(volt_diff >>> EWMA_SHIFT);
                    if (!flags_next.curr_anomaly)
                        curr_base <= curr_base + adc_sample_t'(curr_diff >>> EWMA_SHIFT);
                end
            end
        end
    end

endmodule

// File: source/kavach_pkg.sv
// =========================================================================
// Shared types for the kavach security monitor
// Level and severity encodings are ordered so that plain compares rank them
// =========================================================================

package kavach_pkg;

    localparam int TIMESTAMP_WIDTH = 32;

    typedef logic [11:0] adc_sample_t;

    typedef enum logic [1:0] {
        SEV_NONE   = 2'd0,
        SEV_MINOR  = 2'd1,
        SEV_MAJOR  = 2'd2,
        SEV_SEVERE = 2'd3
    } severity_e;

    // Numeric value of a level equals severity plus escalation
    typedef enum logic [2:0] {
        LVL_NONE     = 3'd0,
        LVL_LOW      = 3'd1,
        LVL_MEDIUM   = 3'd2,
        LVL_HIGH     = 3'd3,
        LVL_CRITICAL = 3'd4
    } threat_level_e;

    typedef enum logic [3:0] {
        ATK_NONE         = 4'd0,
        ATK_POWER_GLITCH = 4'd1,
        ATK_THERMAL      = 4'd2,
        ATK_COMBINED     = 4'd3
    } attack_type_e;

    typedef struct packed {
        logic      volt_anomaly;
        logic      curr_anomaly;
        severity_e severity;
    } power_flags_t;

    typedef struct packed {
        logic      temp_hi;
        logic      temp_lo;
        logic      sustained;
        severity_e severity;
    } temp_flags_t;

    typedef struct packed {
        threat_level_e level;
        attack_type_e  attack_type;
        logic [7:0]    score;
    } threat_t;

    typedef struct packed {
        logic alert_irq;
        logic clk_throttle_en;
        logic bus_isolate;
        logic sys_lockdown;
        logic crypto_zeroize;
    } response_t;

    typedef struct packed {
        logic [TIMESTAMP_WIDTH-1:0] timestamp;
        threat_t                    threat;
        adc_sample_t                snap_vdd;
        adc_sample_t                snap_temp;
    } forensic_entry_t;

endpackage
